//--- rtl/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// widths fixed by the MIPS32 instruction set

// general purpose register and operand width
`define EX_WORD_WIDTH 32

// 32 architectural registers
`define EX_REG_ADDR_WIDTH 5

// shift amount, low bits of operand 1
`define EX_SHAMT_WIDTH 5

`endif

//--- rtl/ex_pkg.sv
`default_nettype none
`include "ex_config.svh"

package ex_pkg;

    typedef logic [`EX_WORD_WIDTH-1:0]     word_t;      // one data word
    typedef logic [2*`EX_WORD_WIDTH-1:0]   dword_t;     // hi:lo pair or full product
    typedef logic [`EX_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`EX_SHAMT_WIDTH-1:0]    shamt_t;

    // operation codes seen by the execute stage
    // addi decodes to OP_ADD with the immediate in operand 2
    typedef enum logic [4:0] {
        OP_OR    = 5'd0,
        OP_AND   = 5'd1,
        OP_NOR   = 5'd2,
        OP_XOR   = 5'd3,
        OP_SLL   = 5'd4,
        OP_SRL   = 5'd5,
        OP_SRA   = 5'd6,
        OP_ADD   = 5'd7,
        OP_ADDU  = 5'd8,
        OP_SUB   = 5'd9,
        OP_SUBU  = 5'd10,
        OP_SLT   = 5'd11,
        OP_SLTU  = 5'd12,
        OP_CLZ   = 5'd13,
        OP_CLO   = 5'd14,
        OP_MULT  = 5'd15,
        OP_MULTU = 5'd16,
        OP_MUL   = 5'd17,
        OP_MADD  = 5'd18,
        OP_MADDU = 5'd19,
        OP_MSUB  = 5'd20,
        OP_MSUBU = 5'd21,
        OP_MFHI  = 5'd22,
        OP_MFLO  = 5'd23,
        OP_MTHI  = 5'd24,
        OP_MTLO  = 5'd25
    } aluop_t;

    // control FSM
    typedef enum logic [1:0] {IDLE, MUL, ACC, DONE} ex_state_t;

    // what the multiplier does with hi:lo after the product
    typedef enum logic [1:0] {NONE, ADD, SUB} mul_mode_t;

endpackage

`default_nettype wire

//--- rtl/ex_if.sv
`timescale 1ns/1ps
`default_nettype none

// control FSM <-> multiplier
interface mul_if;
    logic              start;      // one-cycle pulse
    logic              is_signed;
    ex_pkg::mul_mode_t mode;
    ex_pkg::word_t     a;
    ex_pkg::word_t     b;
    ex_pkg::dword_t    hilo;       // base for madd/msub
    logic              done;       // one pulse per start
    ex_pkg::dword_t    result;

    modport master (output start, is_signed, mode, a, b, hilo,
                    input  done, result);
    modport slave  (input  start, is_signed, mode, a, b, hilo,
                    output done, result);
endinterface

// control FSM <-> hi/lo register pair
interface hilo_if;
    logic          we;
    ex_pkg::word_t wr_hi;
    ex_pkg::word_t wr_lo;
    ex_pkg::word_t hi;             // current contents
    ex_pkg::word_t lo;

    modport master (output we, wr_hi, wr_lo,
                    input  hi, lo);
    modport slave  (input  we, wr_hi, wr_lo,
                    output hi, lo);
endinterface

`default_nettype wire

//--- rtl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_config.svh"

// single-cycle operations, purely combinational
module ex_alu (
    input  wire ex_pkg::aluop_t code_i,
    input  wire ex_pkg::word_t  reg1_i,
    input  wire ex_pkg::word_t  reg2_i,
    output ex_pkg::word_t       result_o,
    output logic                overflow_o
);

    localparam int MSB   = `EX_WORD_WIDTH - 1;
    localparam int CNT_W = $clog2(`EX_WORD_WIDTH) + 1;   // 0..32

    ex_pkg::shamt_t   shamt;
    ex_pkg::word_t    sum;
    logic             is_sub;
    logic [CNT_W-1:0] zeros;
    logic [CNT_W-1:0] ones;

    // scan from the msb until the first set bit
    function automatic logic [CNT_W-1:0] lead_zeros(input ex_pkg::word_t v);
        logic [CNT_W-1:0] n;
        logic             found;
        n     = '0;
        found = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            if (!found && !v[i]) begin
                n = n + 1'b1;
            end else begin
                found = 1'b1;
            end
        end
        return n;
    endfunction

    assign shamt  = reg1_i[`EX_SHAMT_WIDTH-1:0];   // amount from operand 1
    assign is_sub = (code_i == ex_pkg::OP_SUB) || (code_i == ex_pkg::OP_SUBU);
    assign sum    = is_sub ? reg1_i - reg2_i : reg1_i + reg2_i;

    // sign of result differs from operand 1 while the operands agree (add)
    // or disagree (sub) in sign
    assign overflow_o = (reg1_i[MSB] ^ sum[MSB]) & (reg1_i[MSB] ^ reg2_i[MSB] ^ ~is_sub);

    assign zeros = lead_zeros(reg1_i);
    assign ones  = lead_zeros(~reg1_i);        // clo is clz of the inverse

    always_comb begin
        case (code_i)
            ex_pkg::OP_OR:   result_o = reg1_i | reg2_i;
            ex_pkg::OP_AND:  result_o = reg1_i & reg2_i;
            ex_pkg::OP_NOR:  result_o = ~(reg1_i | reg2_i);
            ex_pkg::OP_XOR:  result_o = reg1_i ^ reg2_i;
            ex_pkg::OP_SLL:  result_o = reg2_i << shamt;
            ex_pkg::OP_SRL:  result_o = reg2_i >> shamt;
            ex_pkg::OP_SRA:  result_o = ex_pkg::word_t'($signed(reg2_i) >>> shamt);
            ex_pkg::OP_ADD,
            ex_pkg::OP_ADDU,
            ex_pkg::OP_SUB,
            ex_pkg::OP_SUBU: result_o = sum;
            ex_pkg::OP_SLT:  result_o = ex_pkg::word_t'($signed(reg1_i) < $signed(reg2_i));
            ex_pkg::OP_SLTU: result_o = ex_pkg::word_t'(reg1_i < reg2_i);
            ex_pkg::OP_CLZ:  result_o = ex_pkg::word_t'(zeros);
            ex_pkg::OP_CLO:  result_o = ex_pkg::word_t'(ones);
            default:         result_o = '0;   // multiply and hi/lo moves
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_mul.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_config.svh"

// stage 1: 64-bit product, stage 2 (madd/msub only): hi:lo +/- product
module ex_mul (
    input  wire  clk,
    input  wire  rst_i,
    mul_if.slave mul
);

    localparam int MSB = `EX_WORD_WIDTH - 1;

    logic              neg_a;
    logic              neg_b;
    ex_pkg::word_t     mag_a;
    ex_pkg::word_t     mag_b;
    ex_pkg::dword_t    mag_prod;
    ex_pkg::dword_t    prod_d;

    logic              p1_q;       // product stage valid
    logic              p2_q;       // accumulate stage valid
    ex_pkg::mul_mode_t mode_q;
    ex_pkg::dword_t    prod_q;
    ex_pkg::dword_t    acc_q;

    // multiply magnitudes, fix the sign afterwards
    assign neg_a = mul.is_signed & mul.a[MSB];
    assign neg_b = mul.is_signed & mul.b[MSB];
    assign mag_a = neg_a ? -mul.a : mul.a;
    assign mag_b = neg_b ? -mul.b : mul.b;

    assign mag_prod = ex_pkg::dword_t'(mag_a) * ex_pkg::dword_t'(mag_b);
    assign prod_d   = (neg_a ^ neg_b) ? -mag_prod : mag_prod;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            p1_q <= 1'b0;
            p2_q <= 1'b0;
        end else begin
            p1_q <= mul.start;
            p2_q <= p1_q && (mode_q != ex_pkg::NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (mul.start) begin
            prod_q <= prod_d;
            mode_q <= mul.mode;   // held for stage 2
        end
        if (p1_q && mode_q == ex_pkg::ADD) begin
            acc_q <= mul.hilo + prod_q;
        end else if (p1_q && mode_q == ex_pkg::SUB) begin
            acc_q <= mul.hilo - prod_q;
        end
    end

    assign mul.done   = (p1_q && mode_q == ex_pkg::NONE) || p2_q;
    assign mul.result = p2_q ? acc_q : prod_q;

endmodule

`default_nettype wire

//--- rtl/ex_hilo.sv
`timescale 1ns/1ps
`default_nettype none

// hi/lo special registers, both halves load together
module ex_hilo (
    input  wire   clk,
    input  wire   rst_i,
    hilo_if.slave hilo
);

    ex_pkg::word_t hi_q;
    ex_pkg::word_t lo_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (hilo.we) begin
            hi_q <= hilo.wr_hi;
            lo_q <= hilo.wr_lo;
        end
    end

    // new value visible from the next cycle on
    assign hilo.hi = hi_q;
    assign hilo.lo = lo_q;

endmodule

`default_nettype wire

//--- rtl/ex_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_config.svh"

// operation handshake, result select, hi/lo write decision, output register
module ex_ctrl (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    op_valid_i,
    output logic                   op_ready_o,
    input  wire ex_pkg::aluop_t    op_code_i,
    input  wire ex_pkg::word_t     op_reg1_i,
    input  wire ex_pkg::word_t     op_reg2_i,
    input  wire ex_pkg::reg_addr_t op_wd_i,
    input  wire                    op_wreg_i,
    output logic                   res_valid_o,
    input  wire                    res_ready_i,
    output ex_pkg::reg_addr_t      res_wd_o,
    output logic                   res_wreg_o,
    output ex_pkg::word_t          res_wdata_o,
    output ex_pkg::aluop_t         alu_code_o,
    output ex_pkg::word_t          alu_reg1_o,
    output ex_pkg::word_t          alu_reg2_o,
    input  wire ex_pkg::word_t     alu_result_i,
    input  wire                    alu_overflow_i,
    mul_if.master                  mul,
    hilo_if.master                 hilo
);

    ex_pkg::ex_state_t state_q;
    ex_pkg::ex_state_t state_d;
    ex_pkg::aluop_t    code_q;
    ex_pkg::reg_addr_t wd_q;
    logic              wreg_q;
    ex_pkg::word_t     wdata_q;
    ex_pkg::word_t     single_data;
    logic              accept;
    logic              is_mul;
    logic              ovf_kill;

    assign accept   = op_valid_i & op_ready_o;
    assign is_mul   = op_code_i inside {ex_pkg::OP_MULT, ex_pkg::OP_MULTU, ex_pkg::OP_MUL,
                                        ex_pkg::OP_MADD, ex_pkg::OP_MADDU,
                                        ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU};
    // signed overflow cancels the write, addu/subu never trap
    assign ovf_kill = alu_overflow_i & (op_code_i inside {ex_pkg::OP_ADD, ex_pkg::OP_SUB});

    assign alu_code_o = op_code_i;
    assign alu_reg1_o = op_reg1_i;
    assign alu_reg2_o = op_reg2_i;

    // multiplier request, sampled only with start
    assign mul.start     = accept & is_mul;
    assign mul.is_signed = op_code_i inside {ex_pkg::OP_MULT, ex_pkg::OP_MUL,
                                             ex_pkg::OP_MADD, ex_pkg::OP_MSUB};
    assign mul.a         = op_reg1_i;
    assign mul.b         = op_reg2_i;
    assign mul.hilo      = {hilo.hi, hilo.lo};   // stable while the op is in flight

    always_comb begin
        case (op_code_i)
            ex_pkg::OP_MADD, ex_pkg::OP_MADDU: mul.mode = ex_pkg::ADD;
            ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU: mul.mode = ex_pkg::SUB;
            default:                           mul.mode = ex_pkg::NONE;
        endcase
    end

    always_comb begin
        case (op_code_i)
            ex_pkg::OP_MFHI: single_data = hilo.hi;
            ex_pkg::OP_MFLO: single_data = hilo.lo;
            default:         single_data = alu_result_i;
        endcase
    end

    // hi/lo written on the edge that raises res_valid_o
    always_comb begin
        hilo.we    = 1'b0;
        hilo.wr_hi = hilo.hi;
        hilo.wr_lo = hilo.lo;
        if (accept && op_code_i == ex_pkg::OP_MTHI) begin
            hilo.we    = 1'b1;
            hilo.wr_hi = op_reg1_i;   // lo kept
        end else if (accept && op_code_i == ex_pkg::OP_MTLO) begin
            hilo.we    = 1'b1;
            hilo.wr_lo = op_reg1_i;
        end else if (mul.done && code_q != ex_pkg::OP_MUL) begin
            hilo.we                  = 1'b1;   // mul only writes the gpr
            {hilo.wr_hi, hilo.wr_lo} = mul.result;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ex_pkg::IDLE: begin
                if (accept && is_mul) begin
                    state_d = ex_pkg::MUL;
                end else if (accept) begin
                    state_d = ex_pkg::DONE;
                end
            end
            ex_pkg::MUL: begin
                if (mul.done) begin
                    state_d = ex_pkg::DONE;
                end else begin
                    state_d = ex_pkg::ACC;   // madd/msub, one more cycle
                end
            end
            ex_pkg::ACC:  if (mul.done) state_d = ex_pkg::DONE;
            ex_pkg::DONE: if (res_ready_i) state_d = ex_pkg::IDLE;
            default:      state_d = ex_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ex_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            code_q  <= op_code_i;
            wd_q    <= op_wd_i;
            wreg_q  <= op_wreg_i & ~ovf_kill;
            wdata_q <= single_data;
        end else if (mul.done) begin
            wdata_q <= mul.result[`EX_WORD_WIDTH-1:0];   // low product word
        end
    end

    assign op_ready_o  = (state_q == ex_pkg::IDLE);
    assign res_valid_o = (state_q == ex_pkg::DONE);
    assign res_wd_o    = wd_q;
    assign res_wreg_o  = wreg_q;
    assign res_wdata_o = wdata_q;

endmodule

`default_nettype wire

//--- rtl/ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

// execute unit top level
module ex_unit (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    op_valid_i,
    output logic                   op_ready_o,
    input  wire ex_pkg::aluop_t    op_code_i,
    input  wire ex_pkg::word_t     op_reg1_i,
    input  wire ex_pkg::word_t     op_reg2_i,
    input  wire ex_pkg::reg_addr_t op_wd_i,
    input  wire                    op_wreg_i,
    output logic                   res_valid_o,
    input  wire                    res_ready_i,
    output ex_pkg::reg_addr_t      res_wd_o,
    output logic                   res_wreg_o,
    output ex_pkg::word_t          res_wdata_o
);

    ex_pkg::aluop_t alu_code;
    ex_pkg::word_t  alu_reg1;
    ex_pkg::word_t  alu_reg2;
    ex_pkg::word_t  alu_result;
    logic           alu_overflow;

    mul_if  mul_bus ();
    hilo_if hilo_bus ();

    ex_ctrl u_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .op_valid_i     (op_valid_i),
        .op_ready_o     (op_ready_o),
        .op_code_i      (op_code_i),
        .op_reg1_i      (op_reg1_i),
        .op_reg2_i      (op_reg2_i),
        .op_wd_i        (op_wd_i),
        .op_wreg_i      (op_wreg_i),
        .res_valid_o    (res_valid_o),
        .res_ready_i    (res_ready_i),
        .res_wd_o       (res_wd_o),
        .res_wreg_o     (res_wreg_o),
        .res_wdata_o    (res_wdata_o),
        .alu_code_o     (alu_code),
        .alu_reg1_o     (alu_reg1),
        .alu_reg2_o     (alu_reg2),
        .alu_result_i   (alu_result),
        .alu_overflow_i (alu_overflow),
        .mul            (mul_bus.master),
        .hilo           (hilo_bus.master)
    );

    ex_alu u_alu (
        .code_i     (alu_code),
        .reg1_i     (alu_reg1),
        .reg2_i     (alu_reg2),
        .result_o   (alu_result),
        .overflow_o (alu_overflow)
    );

    ex_mul u_mul (
        .clk   (clk),
        .rst_i (rst_i),
        .mul   (mul_bus.slave)
    );

    ex_hilo u_hilo (
        .clk   (clk),
        .rst_i (rst_i),
        .hilo  (hilo_bus.slave)
    );

endmodule

`default_nettype wire

//--- test/ex_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// handshake rules on both sides of the execute unit
module ex_unit_asserts (
    input wire                    clk,
    input wire                    rst_i,
    input wire                    op_valid_i,
    input wire                    op_ready_o,
    input wire                    res_valid_o,
    input wire                    res_ready_i,
    input wire ex_pkg::reg_addr_t res_wd_o,
    input wire                    res_wreg_o,
    input wire ex_pkg::word_t     res_wdata_o
);

    int fail_count = 0;   // failed assertions so far

    // an offered op stays offered until taken
    op_hold: assert property (@(posedge clk) disable iff (rst_i)
        op_valid_i && !op_ready_o |=> op_valid_i)
        else begin
            $error("op_valid_i dropped before acceptance");
            fail_count++;
        end

    res_hold: assert property (@(posedge clk) disable iff (rst_i)
        res_valid_o && !res_ready_i |=> res_valid_o)
        else begin
            $error("res_valid_o dropped before transfer");
            fail_count++;
        end

    res_stable: assert property (@(posedge clk) disable iff (rst_i)
        res_valid_o && !res_ready_i |=>
            $stable(res_wdata_o) && $stable(res_wd_o) && $stable(res_wreg_o))
        else begin
            $error("result changed under back-pressure");
            fail_count++;
        end

    one_side: assert property (@(posedge clk) disable iff (rst_i)
        !(op_ready_o && res_valid_o))
        else begin
            $error("op_ready_o and res_valid_o both high");
            fail_count++;
        end

    reset_idle: assert property (@(posedge clk) rst_i |=> !res_valid_o)
        else begin
            $error("res_valid_o high after reset");
            fail_count++;
        end

endmodule

bind ex_unit ex_unit_asserts u_asserts (.*);

`default_nettype wire

//--- test/ex_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit_tb;

    localparam int TIMEOUT = 50;   // cycles per wait

    logic              clk;
    logic              rst_i;
    logic              op_valid_i;
    logic              op_ready_o;
    ex_pkg::aluop_t    op_code_i;
    ex_pkg::word_t     op_reg1_i;
    ex_pkg::word_t     op_reg2_i;
    ex_pkg::reg_addr_t op_wd_i;
    logic              op_wreg_i;
    logic              res_valid_o;
    logic              res_ready_i;
    ex_pkg::reg_addr_t res_wd_o;
    logic              res_wreg_o;
    ex_pkg::word_t     res_wdata_o;

    ex_pkg::word_t     lcg_state;
    ex_pkg::dword_t    hilo_m;         // reference hi:lo
    int                tests;
    int                checks;
    int                errors;

    ex_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic ex_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};   // upper bits are the better ones
    endfunction

    function automatic ex_pkg::word_t lead_count(input ex_pkg::word_t v, input logic b);
        int n;
        n = 0;
        while (n < 32 && v[31-n] == b) begin
            n++;
        end
        return ex_pkg::word_t'(n);
    endfunction

    // single-cycle results straight from the instruction rules
    function automatic ex_pkg::word_t model_alu(input ex_pkg::aluop_t code,
                                                input ex_pkg::word_t a, input ex_pkg::word_t b);
        int sh;
        sh = a[4:0];
        case (code)
            ex_pkg::OP_OR:   return a | b;
            ex_pkg::OP_AND:  return a & b;
            ex_pkg::OP_NOR:  return ~(a | b);
            ex_pkg::OP_XOR:  return a ^ b;
            ex_pkg::OP_SLL:  return b << sh;
            ex_pkg::OP_SRL:  return b >> sh;
            ex_pkg::OP_SRA:  return (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ex_pkg::OP_ADD,
            ex_pkg::OP_ADDU: return a + b;
            ex_pkg::OP_SUB,
            ex_pkg::OP_SUBU: return a - b;
            ex_pkg::OP_SLT:  return {31'h0, (a[31] != b[31]) ? a[31] : (a < b)};
            ex_pkg::OP_SLTU: return {31'h0, a < b};
            ex_pkg::OP_CLZ:  return lead_count(a, 1'b0);
            ex_pkg::OP_CLO:  return lead_count(a, 1'b1);
            default:         return '0;
        endcase
    endfunction

    function automatic logic model_ovf(input ex_pkg::aluop_t code,
                                       input ex_pkg::word_t a, input ex_pkg::word_t b);
        logic [32:0] s;   // one guard bit
        s = (code == ex_pkg::OP_SUB) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
        return (code == ex_pkg::OP_ADD || code == ex_pkg::OP_SUB) && (s[32] != s[31]);
    endfunction

    function automatic ex_pkg::dword_t product(input logic sgn, input ex_pkg::word_t a,
                                               input ex_pkg::word_t b);
        ex_pkg::dword_t xa;
        ex_pkg::dword_t xb;
        xa = {sgn ? {32{a[31]}} : 32'h0, a};
        xb = {sgn ? {32{b[31]}} : 32'h0, b};
        return xa * xb;   // low 64 bits of the extended product
    endfunction

    function automatic int latency(input ex_pkg::aluop_t code);
        case (code)
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU, ex_pkg::OP_MUL: return 2;
            ex_pkg::OP_MADD, ex_pkg::OP_MADDU, ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU: return 3;
            default: return 1;
        endcase
    endfunction

    task automatic check_word(input string name, input ex_pkg::word_t got,
                              input ex_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg_addr(input string name, input ex_pkg::reg_addr_t got,
                                  input ex_pkg::reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input ex_pkg::aluop_t code, input int got);
        checks++;
        if (got != latency(code)) begin
            $display("%s took %0d cycles instead of %0d", code.name(), got, latency(code));
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("Simulation FAILED");
        $finish;
    endtask

    // called and left on a falling edge
    task automatic send_op(input ex_pkg::aluop_t code, input ex_pkg::word_t a,
                           input ex_pkg::word_t b, input ex_pkg::reg_addr_t wd,
                           input logic wreg);
        int t;
        t = 0;
        while (!op_ready_o) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                stop_on_timeout("op_ready_o");
            end
        end
        op_valid_i = 1'b1;
        op_code_i  = code;
        op_reg1_i  = a;
        op_reg2_i  = b;
        op_wd_i    = wd;
        op_wreg_i  = wreg;
        @(negedge clk);   // taken on the rising edge in between
        op_valid_i = 1'b0;
    endtask

    task automatic collect_result(output ex_pkg::reg_addr_t wd, output logic wreg,
                                  output ex_pkg::word_t data, output int cycles);
        int t;
        t = 0;
        res_ready_i = 1'b1;
        while (!res_valid_o) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                stop_on_timeout("res_valid_o");
            end
        end
        wd     = res_wd_o;
        wreg   = res_wreg_o;
        data   = res_wdata_o;
        cycles = t + 1;
        @(negedge clk);
        res_ready_i = 1'b0;
    endtask

    // one operation against the reference, hi:lo model updated on the way
    task automatic run_op(input ex_pkg::aluop_t code, input ex_pkg::word_t a,
                          input ex_pkg::word_t b);
        ex_pkg::dword_t    prod;
        ex_pkg::word_t     exp_data;
        ex_pkg::word_t     rnd;
        ex_pkg::reg_addr_t wd;
        logic              wreg;
        ex_pkg::reg_addr_t got_wd;
        logic              got_wreg;
        ex_pkg::word_t     got_data;
        int                got_lat;
        logic              sgn;
        logic              chk_data;
        rnd      = lcg_next();
        wd       = ex_pkg::reg_addr_t'(rnd);
        // add and sub always ask for the write so that overflow can cancel it
        wreg     = rnd[8] | (code inside {ex_pkg::OP_ADD, ex_pkg::OP_ADDU,
                                          ex_pkg::OP_SUB, ex_pkg::OP_SUBU});
        sgn      = code == ex_pkg::OP_MULT || code == ex_pkg::OP_MUL ||
                   code == ex_pkg::OP_MADD || code == ex_pkg::OP_MSUB;
        prod     = product(sgn, a, b);
        exp_data = model_alu(code, a, b);
        chk_data = (latency(code) == 1 || code == ex_pkg::OP_MUL) &&
                   code != ex_pkg::OP_MTHI && code != ex_pkg::OP_MTLO;
        case (code)
            ex_pkg::OP_MFHI:                   exp_data = hilo_m[63:32];
            ex_pkg::OP_MFLO:                   exp_data = hilo_m[31:0];
            ex_pkg::OP_MTHI:                   hilo_m[63:32] = a;   // lo untouched
            ex_pkg::OP_MTLO:                   hilo_m[31:0] = a;
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU: hilo_m = prod;
            ex_pkg::OP_MUL:                    exp_data = prod[31:0];
            ex_pkg::OP_MADD, ex_pkg::OP_MADDU: hilo_m = hilo_m + prod;
            ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU: hilo_m = hilo_m - prod;
            default: ;
        endcase
        send_op(code, a, b, wd, wreg);
        collect_result(got_wd, got_wreg, got_data, got_lat);
        if (chk_data) begin
            check_word("res_wdata_o", got_data, exp_data);
        end
        check_reg_addr("res_wd_o", got_wd, wd);
        check_flag("res_wreg_o", got_wreg, wreg && !model_ovf(code, a, b));
        check_latency(code, got_lat);
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        check_flag("op_ready_o", op_ready_o, 1'b1);
        check_flag("res_valid_o", res_valid_o, 1'b0);
        run_op(ex_pkg::OP_MFHI, lcg_next(), lcg_next());
        run_op(ex_pkg::OP_MFLO, lcg_next(), lcg_next());
        finish_test("reset", err0);
    endtask

    task automatic test_logic();
        int err0;
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            for (int c = 0; c <= 6; c++) begin   // or .. sra
                run_op(ex_pkg::aluop_t'(c), lcg_next(), lcg_next());
            end
        end
        finish_test("logic and shift", err0);
    endtask

    task automatic test_arith();
        ex_pkg::word_t edge_a [6] = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000,
                                      32'h7fff_ffff, 32'h0000_0000, 32'hffff_ffff};
        ex_pkg::word_t edge_b [6] = '{32'h0000_0001, 32'hffff_ffff, 32'h0000_0001,
                                      32'hffff_ffff, 32'h0000_0000, 32'h0000_0000};
        int err0;
        err0 = errors;
        for (int i = 0; i < 14; i++) begin
            for (int c = 7; c <= 14; c++) begin   // add .. clo
                if (i < 6) begin
                    run_op(ex_pkg::aluop_t'(c), edge_a[i], edge_b[i]);
                end else begin
                    run_op(ex_pkg::aluop_t'(c), lcg_next(), lcg_next());
                end
            end
        end
        finish_test("arithmetic", err0);
    endtask

    task automatic test_mul();
        ex_pkg::word_t a;
        ex_pkg::word_t b;
        int            err0;
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            a = (i == 0) ? 32'h8000_0000 : lcg_next();
            b = (i == 0) ? 32'hffff_ffff : lcg_next();
            run_op(ex_pkg::OP_MULT, a, b);
            run_op(ex_pkg::OP_MFHI, 32'h0, 32'h0);
            run_op(ex_pkg::OP_MFLO, 32'h0, 32'h0);
            run_op(ex_pkg::OP_MULTU, a, b);
            run_op(ex_pkg::OP_MFHI, 32'h0, 32'h0);
            run_op(ex_pkg::OP_MFLO, 32'h0, 32'h0);
            run_op(ex_pkg::OP_MUL, a, b);
        end
        finish_test("multiply", err0);
    endtask

    task automatic test_acc();
        int err0;
        err0 = errors;
        run_op(ex_pkg::OP_MTHI, lcg_next(), 32'h0);
        run_op(ex_pkg::OP_MTLO, lcg_next(), 32'h0);
        run_op(ex_pkg::OP_MTHI, lcg_next(), 32'h0);
        run_op(ex_pkg::OP_MFLO, 32'h0, 32'h0);   // lo must survive mthi
        run_op(ex_pkg::OP_MFHI, 32'h0, 32'h0);
        for (int i = 0; i < 4; i++) begin
            for (int c = 18; c <= 21; c++) begin   // madd .. msubu
                run_op(ex_pkg::aluop_t'(c), lcg_next(), lcg_next());
                run_op(ex_pkg::OP_MFHI, 32'h0, 32'h0);
                run_op(ex_pkg::OP_MFLO, 32'h0, 32'h0);
            end
        end
        finish_test("accumulate", err0);
    endtask

    task automatic test_backpressure();
        ex_pkg::word_t     a;
        ex_pkg::word_t     b;
        ex_pkg::reg_addr_t got_wd;
        logic              got_wreg;
        ex_pkg::word_t     got_data;
        int                got_lat;
        int                n;
        int                err0;
        err0 = errors;
        for (int k = 0; k < 4; k++) begin
            a = lcg_next();
            b = lcg_next();
            n = int'(lcg_next() % 8) + 2;
            send_op(ex_pkg::OP_XOR, a, b, 5'd7, 1'b1);
            // next op offered while the result is stuck
            op_valid_i = 1'b1;
            op_code_i  = ex_pkg::OP_ADDU;
            op_reg1_i  = b;
            op_reg2_i  = a;
            op_wd_i    = 5'd9;
            op_wreg_i  = 1'b1;
            repeat (n) begin
                check_flag("op_ready_o", op_ready_o, 1'b0);
                check_flag("res_valid_o", res_valid_o, 1'b1);
                check_word("res_wdata_o", res_wdata_o, a ^ b);
                check_reg_addr("res_wd_o", res_wd_o, 5'd7);
                @(negedge clk);
            end
            collect_result(got_wd, got_wreg, got_data, got_lat);
            check_word("res_wdata_o", got_data, a ^ b);
            check_reg_addr("res_wd_o", got_wd, 5'd7);
            check_flag("res_wreg_o", got_wreg, 1'b1);
            send_op(ex_pkg::OP_ADDU, b, a, 5'd9, 1'b1);   // still offered, taken once
            collect_result(got_wd, got_wreg, got_data, got_lat);
            check_word("res_wdata_o", got_data, a + b);
            check_reg_addr("res_wd_o", got_wd, 5'd9);
            check_flag("res_wreg_o", got_wreg, 1'b1);
            check_latency(ex_pkg::OP_ADDU, got_lat);
            check_flag("res_valid_o", res_valid_o, 1'b0);   // no second copy
        end
        finish_test("back-pressure", err0);
    endtask

    initial begin
        lcg_state   = 32'd42874;
        hilo_m      = '0;
        tests       = 0;
        checks      = 0;
        errors      = 0;
        rst_i       = 1'b1;
        op_valid_i  = 1'b0;
        op_code_i   = ex_pkg::OP_OR;
        op_reg1_i   = '0;
        op_reg2_i   = '0;
        op_wd_i     = '0;
        op_wreg_i   = 1'b0;
        res_ready_i = 1'b0;
        repeat (5) @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        test_reset();
        test_logic();
        test_arith();
        test_mul();
        test_acc();
        test_backpressure();
        errors = errors + uut.u_asserts.fail_count;   // handshake rule violations
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ex_unit.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_if.sv
rtl/ex_alu.sv
rtl/ex_mul.sv
rtl/ex_hilo.sv
rtl/ex_ctrl.sv
rtl/ex_unit.sv
test/ex_unit_asserts.sv
test/ex_unit_tb.sv

//--- Bender.yml
package:
  name: ex_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ex_pkg.sv
      - rtl/ex_if.sv
      - rtl/ex_alu.sv
      - rtl/ex_mul.sv
      - rtl/ex_hilo.sv
      - rtl/ex_ctrl.sv
      - rtl/ex_unit.sv
  - target: test
    files:
      - test/ex_unit_asserts.sv
      - test/ex_unit_tb.sv
